//--- rtl/arcade_input_pkg.sv
/* Arcade input shared definitions */

package arcade_input_pkg;

	// One player's controls, right in bit 0 as on a joystick word
	typedef struct packed {
		logic coin;
		logic start;
		logic fire_d;
		logic fire_c;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} player_t;

	typedef struct packed {
		player_t p4;
		player_t p3;
		player_t p2;
		player_t p1;
	} joy_bank_t;

	// Keyboard players leave their coin field at zero
	typedef struct packed {
		logic coin3;
		logic coin2;
		logic coin1;
		player_t p2;
		player_t p1;
	} key_buttons_t;

	typedef struct packed {
		logic wr;
		logic [7:0] index;
		logic [24:0] addr;
		logic [7:0] data;
	} dl_write_t;

	typedef struct packed {
		logic [7:0] input4;
		logic [7:0] input3;
		logic [7:0] input2;
		logic [7:0] input1;
		logic [7:0] input0;
	} port_bank_t;

	typedef enum logic [2:0] {
		GAME_RAMPAGE = 3'd0,
		GAME_SARGE = 3'd1,
		GAME_POWERDRIVE = 3'd2,
		GAME_MAXRPM = 3'd3,
		GAME_NONE = 3'd7
	} game_t;

	typedef struct packed {
		logic [2:0] powerdrv_gear;
		logic [2:0] maxrpm_gear1;
		logic [2:0] maxrpm_gear2;
	} gear_state_t;

	localparam logic [7:0] GAME_SELECT_INDEX = 8'd1;
	localparam logic [7:0] DIP_INDEX = 8'd254;
	localparam int DIP_BYTES_DEFAULT = 8;

	// ========================================================================
	// Scan codes
	// ========================================================================
	localparam logic [7:0] KEY_P1_UP = 8'h75;
	localparam logic [7:0] KEY_P1_DOWN = 8'h72;
	localparam logic [7:0] KEY_P1_LEFT = 8'h6B;
	localparam logic [7:0] KEY_P1_RIGHT = 8'h74;
	localparam logic [7:0] KEY_P1_FIRE_A = 8'h14;
	localparam logic [7:0] KEY_P1_FIRE_B = 8'h11;
	localparam logic [7:0] KEY_P1_FIRE_C = 8'h29;
	localparam logic [7:0] KEY_P1_FIRE_D = 8'h12;
	localparam logic [7:0] KEY_F1 = 8'h05;
	localparam logic [7:0] KEY_1 = 8'h16;
	localparam logic [7:0] KEY_F2 = 8'h06;
	localparam logic [7:0] KEY_2 = 8'h1E;
	localparam logic [7:0] KEY_ESC = 8'h76;
	localparam logic [7:0] KEY_5 = 8'h2E;
	localparam logic [7:0] KEY_6 = 8'h36;
	localparam logic [7:0] KEY_7 = 8'h3D;
	localparam logic [7:0] KEY_P2_UP = 8'h2D;
	localparam logic [7:0] KEY_P2_DOWN = 8'h2B;
	localparam logic [7:0] KEY_P2_LEFT = 8'h23;
	localparam logic [7:0] KEY_P2_RIGHT = 8'h34;
	localparam logic [7:0] KEY_P2_FIRE_A = 8'h1C;
	localparam logic [7:0] KEY_P2_FIRE_B = 8'h1B;
	localparam logic [7:0] KEY_P2_FIRE_C = 8'h21;
	localparam logic [7:0] KEY_P2_FIRE_D = 8'h1D;

	// Max RPM gearbox switch pattern per gear position
	localparam logic [3:0] MAXRPM_GEAR_BITS [0:4] = '{4'h0, 4'h5, 4'h6, 4'h1, 4'h2};
	localparam logic [2:0] MAXRPM_GEAR_MAX = 3'd4;

endpackage

//--- rtl/key_decoder.sv
/* Keyboard event decoder */

`timescale 1ns/1ns

module key_decoder (
	input logic clk_sys,
	input logic reset,
	input logic [10:0] ps2_key,
	output arcade_input_pkg::key_buttons_t buttons
);

	logic toggle_q;
	logic toggle_prev;
	logic pressed_q;
	logic [7:0] code_q;

	// Input stage, keeps following the keyboard through reset
	always_ff @(posedge clk_sys) begin
		toggle_q <= ps2_key[10];
		toggle_prev <= toggle_q;
		pressed_q <= ps2_key[9];
		code_q <= ps2_key[7:0];
	end

	// Event when the toggle bit moves
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			buttons <= '0;
		end else if (toggle_q != toggle_prev) begin
			case (code_q)
				arcade_input_pkg::KEY_P1_UP: buttons.p1.up <= pressed_q;
				arcade_input_pkg::KEY_P1_DOWN: buttons.p1.down <= pressed_q;
				arcade_input_pkg::KEY_P1_LEFT: buttons.p1.left <= pressed_q;
				arcade_input_pkg::KEY_P1_RIGHT: buttons.p1.right <= pressed_q;
				arcade_input_pkg::KEY_P1_FIRE_A: buttons.p1.fire_a <= pressed_q;
				arcade_input_pkg::KEY_P1_FIRE_B: buttons.p1.fire_b <= pressed_q;
				arcade_input_pkg::KEY_P1_FIRE_C: buttons.p1.fire_c <= pressed_q;
				arcade_input_pkg::KEY_P1_FIRE_D: buttons.p1.fire_d <= pressed_q;
				// Function key or MAME style digit
				arcade_input_pkg::KEY_F1,
				arcade_input_pkg::KEY_1: buttons.p1.start <= pressed_q;
				arcade_input_pkg::KEY_F2,
				arcade_input_pkg::KEY_2: buttons.p2.start <= pressed_q;
				arcade_input_pkg::KEY_ESC,
				arcade_input_pkg::KEY_5: buttons.coin1 <= pressed_q;
				arcade_input_pkg::KEY_6: buttons.coin2 <= pressed_q;
				arcade_input_pkg::KEY_7: buttons.coin3 <= pressed_q;
				arcade_input_pkg::KEY_P2_UP: buttons.p2.up <= pressed_q;
				arcade_input_pkg::KEY_P2_DOWN: buttons.p2.down <= pressed_q;
				arcade_input_pkg::KEY_P2_LEFT: buttons.p2.left <= pressed_q;
				arcade_input_pkg::KEY_P2_RIGHT: buttons.p2.right <= pressed_q;
				arcade_input_pkg::KEY_P2_FIRE_A: buttons.p2.fire_a <= pressed_q;
				arcade_input_pkg::KEY_P2_FIRE_B: buttons.p2.fire_b <= pressed_q;
				arcade_input_pkg::KEY_P2_FIRE_C: buttons.p2.fire_c <= pressed_q;
				arcade_input_pkg::KEY_P2_FIRE_D: buttons.p2.fire_d <= pressed_q;
				default: ;
			endcase
		end
	end

endmodule

//--- rtl/config_regs.sv
/* Game select and DIP switches */

`timescale 1ns/1ns

module config_regs #(
	parameter int DIP_BYTES = 8
) (
	input logic clk_sys,
	input logic reset,
	input arcade_input_pkg::dl_write_t dl,
	output arcade_input_pkg::game_t game,
	output logic [7:0] dip0,
	output logic dip_flag
);

	localparam int SLOT_W = (DIP_BYTES > 1) ? $clog2(DIP_BYTES) : 1;

	logic [7:0] select_q;
	logic [7:0] dip_q [DIP_BYTES];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			select_q <= 8'd0;
			for (int i = 0; i < DIP_BYTES; i++) begin
				dip_q[i] <= 8'hFF;
			end
		end else if (dl.wr) begin
			if (dl.index == arcade_input_pkg::GAME_SELECT_INDEX) begin
				select_q <= dl.data;
			end
			// Bytes past the bank are dropped
			if (dl.index == arcade_input_pkg::DIP_INDEX && dl.addr < 25'(DIP_BYTES)) begin
				dip_q[dl.addr[SLOT_W-1:0]] <= dl.data;
			end
		end
	end

	// Registered decode of the select byte
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			game <= arcade_input_pkg::GAME_RAMPAGE;
		end else begin
			case (select_q)
				8'd0: game <= arcade_input_pkg::GAME_RAMPAGE;
				8'd1: game <= arcade_input_pkg::GAME_SARGE;
				8'd2: game <= arcade_input_pkg::GAME_POWERDRIVE;
				8'd3: game <= arcade_input_pkg::GAME_MAXRPM;
				default: game <= arcade_input_pkg::GAME_NONE;
			endcase
		end
	end

	assign dip0 = dip_q[0];
	assign dip_flag = dip_q[1][0];

endmodule

//--- rtl/gear_shifters.sv
/* Power Drive and Max RPM gears */

`timescale 1ns/1ns

module gear_shifters (
	input logic clk_sys,
	input logic reset,
	input arcade_input_pkg::player_t [3:0] merged,
	output arcade_input_pkg::gear_state_t gears
);

	// Sampled button levels and their previous values
	logic [2:0] shift_q;
	logic [2:0] shift_prev;
	logic [1:0] up_q;
	logic [1:0] up_prev;
	logic [1:0] down_q;
	logic [1:0] down_prev;
	logic [1:0] start_q;

	logic [1:0] up_rise;
	logic [1:0] down_rise;

	// Start wins, then shift up, then shift down
	function automatic logic [2:0] next_gear(
		input logic [2:0] gear,
		input logic start,
		input logic up,
		input logic down
	);
		if (start)
			return 3'd0;
		if (up && gear != arcade_input_pkg::MAXRPM_GEAR_MAX)
			return gear + 3'd1;
		if (down && gear != 3'd0)
			return gear - 3'd1;
		return gear;
	endfunction

	assign up_rise = up_q & ~up_prev;
	assign down_rise = down_q & ~down_prev;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			shift_q <= '0;
			shift_prev <= '0;
			up_q <= '0;
			up_prev <= '0;
			down_q <= '0;
			down_prev <= '0;
			start_q <= '0;
			gears <= '0;
		end else begin
			shift_q <= {merged[2].fire_d, merged[1].fire_d, merged[0].fire_d};
			shift_prev <= shift_q;
			up_q <= {merged[1].fire_a, merged[0].fire_a};
			up_prev <= up_q;
			down_q <= {merged[1].fire_b, merged[0].fire_b};
			down_prev <= down_q;
			start_q <= {merged[1].start, merged[0].start};

			// Power Drive high/low toggle per player
			gears.powerdrv_gear <= gears.powerdrv_gear ^ (shift_q & ~shift_prev);
			gears.maxrpm_gear1 <= next_gear(gears.maxrpm_gear1, start_q[0],
				up_rise[0], down_rise[0]);
			gears.maxrpm_gear2 <= next_gear(gears.maxrpm_gear2, start_q[1],
				up_rise[1], down_rise[1]);
		end
	end

endmodule

//--- rtl/input_ports.sv
/* Game input port builder */

`timescale 1ns/1ns

module input_ports (
	input arcade_input_pkg::key_buttons_t buttons,
	input arcade_input_pkg::joy_bank_t joy,
	input arcade_input_pkg::game_t game,
	input logic [7:0] dip0,
	input logic dip_flag,
	input logic dual_stick,
	input logic snd_stat,
	input arcade_input_pkg::gear_state_t gears,
	output arcade_input_pkg::player_t [3:0] merged,
	output arcade_input_pkg::port_bank_t ports
);

	logic any_coin;
	logic [3:0] stick1;
	logic [3:0] stick2;

	// Sarge sticks as {rd, ru, ld, lu}
	function automatic logic [3:0] two_sticks(
		input arcade_input_pkg::player_t p,
		input logic dual
	);
		if (dual)
			return {p.down | p.right, p.up | p.left, p.down | p.left, p.up | p.right};
		return {p.fire_b, p.fire_c, p.down, p.up};
	endfunction

	assign any_coin = buttons.coin1 | buttons.coin2 | buttons.coin3 |
		joy.p1.coin | joy.p2.coin | joy.p3.coin | joy.p4.coin;

	// ========================================================================
	// Keyboard and joystick merge
	// ========================================================================
	always_comb begin
		merged[0] = arcade_input_pkg::player_t'(buttons.p1 | joy.p1);
		merged[1] = arcade_input_pkg::player_t'(buttons.p2 | joy.p2);
		merged[2] = joy.p3;
		merged[3] = joy.p4;
		// Coin slots are separate only on Power Drive
		if (game == arcade_input_pkg::GAME_POWERDRIVE) begin
			merged[0].coin = buttons.coin1 | joy.p1.coin;
			merged[1].coin = buttons.coin2 | joy.p2.coin;
			merged[2].coin = joy.p3.coin;
		end else begin
			merged[0].coin = any_coin;
			merged[1].coin = 1'b0;
			merged[2].coin = 1'b0;
		end
		merged[3].coin = 1'b0;
	end

	assign stick1 = two_sticks(merged[0], dual_stick);
	assign stick2 = two_sticks(merged[1], dual_stick);

	// ========================================================================
	// Port layouts, active low
	// ========================================================================
	always_comb begin
		ports.input0 = 8'hFF;
		ports.input1 = 8'hFF;
		ports.input2 = 8'hFF;
		ports.input3 = dip0;
		ports.input4 = 8'hFF;
		case (game)
			arcade_input_pkg::GAME_RAMPAGE: begin
				ports.input0 = ~{2'b00, dip_flag, 3'b000, merged[1].coin, merged[0].coin};
				ports.input1 = ~{2'b00, merged[0].fire_b, merged[0].fire_a,
					merged[0].left, merged[0].down, merged[0].right, merged[0].up};
				ports.input2 = ~{2'b00, merged[1].fire_b, merged[1].fire_a,
					merged[1].left, merged[1].down, merged[1].right, merged[1].up};
				ports.input4 = ~{snd_stat, 1'b0, merged[2].fire_b, merged[2].fire_a,
					merged[2].left, merged[2].down, merged[2].right, merged[2].up};
			end
			arcade_input_pkg::GAME_SARGE: begin
				ports.input0 = ~{2'b00, dip_flag, 1'b0, merged[1].start, merged[0].start,
					merged[1].coin, merged[0].coin};
				ports.input1 = ~{merged[0].fire_d, merged[0].fire_d,
					merged[0].fire_a, merged[0].fire_a, stick1};
				ports.input2 = ~{merged[1].fire_d, merged[1].fire_d,
					merged[1].fire_a, merged[1].fire_a, stick2};
			end
			arcade_input_pkg::GAME_POWERDRIVE: begin
				ports.input0 = ~{2'b00, dip_flag, 2'b00, merged[2].coin, merged[1].coin,
					merged[0].coin};
				ports.input1 = ~{merged[1].fire_b, merged[1].fire_a, gears.powerdrv_gear[1],
					merged[1].fire_c, merged[0].fire_b, merged[0].fire_a,
					gears.powerdrv_gear[0], merged[0].fire_c};
				ports.input2 = ~{snd_stat, 3'b000, merged[2].fire_b, merged[2].fire_a,
					gears.powerdrv_gear[2], merged[2].fire_c};
			end
			arcade_input_pkg::GAME_MAXRPM: begin
				// Start and coin order swapped on this board
				ports.input0 = ~{dip_flag, 3'b000, merged[0].start, merged[1].start,
					merged[0].coin, merged[1].coin};
				ports.input2 = ~{arcade_input_pkg::MAXRPM_GEAR_BITS[gears.maxrpm_gear1],
					arcade_input_pkg::MAXRPM_GEAR_BITS[gears.maxrpm_gear2]};
			end
			default: ;
		endcase
	end

endmodule

//--- rtl/arcade_inputs_top.sv
/* Arcade player inputs top level */

`timescale 1ns/1ns

module arcade_inputs_top #(
	parameter int DIP_BYTES = arcade_input_pkg::DIP_BYTES_DEFAULT
) (
	input logic clk_sys,
	input logic reset,
	input logic [10:0] ps2_key,
	input arcade_input_pkg::joy_bank_t joy,
	input arcade_input_pkg::dl_write_t dl,
	input logic dual_stick,
	input logic snd_stat,
	output arcade_input_pkg::port_bank_t ports
);

	arcade_input_pkg::key_buttons_t buttons;
	arcade_input_pkg::game_t game;
	logic [7:0] dip0;
	logic dip_flag;
	arcade_input_pkg::player_t [3:0] merged;
	arcade_input_pkg::gear_state_t gears;

	key_decoder u_keys (
		.clk_sys (clk_sys),
		.reset (reset),
		.ps2_key (ps2_key),
		.buttons (buttons)
	);

	config_regs #(
		.DIP_BYTES (DIP_BYTES)
	) u_config (
		.clk_sys (clk_sys),
		.reset (reset),
		.dl (dl),
		.game (game),
		.dip0 (dip0),
		.dip_flag (dip_flag)
	);

	// Gears feed back from the merged controls
	gear_shifters u_gears (
		.clk_sys (clk_sys),
		.reset (reset),
		.merged (merged),
		.gears (gears)
	);

	input_ports u_ports (
		.buttons (buttons),
		.joy (joy),
		.game (game),
		.dip0 (dip0),
		.dip_flag (dip_flag),
		.dual_stick (dual_stick),
		.snd_stat (snd_stat),
		.gears (gears),
		.merged (merged),
		.ports (ports)
	);

endmodule

//--- bench/input_checker.sv
/* Input port checker */

`timescale 1ns/1ns

module input_checker (
	input logic clk_sys,
	input arcade_input_pkg::port_bank_t ports,
	input logic check_en,
	input arcade_input_pkg::port_bank_t expected,
	input logic test_end,
	input logic [7:0] test_id,
	output int errors,
	output int checks,
	output int tests_run,
	output int tests_failed
);

	int error_count = 0;
	int check_count = 0;
	int run_count = 0;
	int failed_count = 0;
	int test_errors = 0;
	int test_checks = 0;

	assign errors = error_count;
	assign checks = check_count;
	assign tests_run = run_count;
	assign tests_failed = failed_count;

	task automatic compare_byte(input string name, input logic [7:0] got,
		input logic [7:0] want);
		if (got !== want) begin
			$display("** Error at %0t ns: %s = %02h, expected %02h", $time, name, got, want);
			error_count++;
			test_errors++;
		end
	endtask

	// Ports settle during the high phase, so compare on the falling edge
	always @(negedge clk_sys) begin
		if (check_en) begin
			check_count++;
			test_checks++;
			compare_byte("ports.input0", ports.input0, expected.input0);
			compare_byte("ports.input1", ports.input1, expected.input1);
			compare_byte("ports.input2", ports.input2, expected.input2);
			compare_byte("ports.input3", ports.input3, expected.input3);
			compare_byte("ports.input4", ports.input4, expected.input4);
		end
		if (test_end) begin
			run_count++;
			if (test_errors == 0) begin
				$display("Test %0d passed, %0d checks", test_id, test_checks);
			end else begin
				$display("Test %0d failed, %0d wrong bytes in %0d checks",
					test_id, test_errors, test_checks);
				failed_count++;
			end
			test_errors = 0;
			test_checks = 0;
		end
	end

endmodule

//--- bench/arcade_inputs_sva.sv
/* Gear state assertions */

`timescale 1ns/1ns

module arcade_inputs_sva (
	input logic clk_sys,
	input logic reset,
	input arcade_input_pkg::gear_state_t gears
);

	gears_cleared: assert property (@(posedge clk_sys) reset |=> gears == '0)
		else $error("Gears not zero one cycle after reset");

	// Max RPM gearbox has five positions
	gear1_range: assert property (@(posedge clk_sys) disable iff (reset)
		gears.maxrpm_gear1 <= 3'd4)
		else $error("Max RPM gear 1 above position 4");

	gear2_range: assert property (@(posedge clk_sys) disable iff (reset)
		gears.maxrpm_gear2 <= 3'd4)
		else $error("Max RPM gear 2 above position 4");

endmodule

bind gear_shifters arcade_inputs_sva gear_checks (
	.clk_sys (clk_sys),
	.reset (reset),
	.gears (gears)
);

//--- bench/tb_arcade_inputs.sv
/* Arcade inputs testbench */

`timescale 1ns/1ns

module tb_arcade_inputs;

	localparam int MAX_STEPS = 128;

	logic clk_sys = 1'b0;
	logic reset;
	logic [10:0] ps2_key;
	arcade_input_pkg::joy_bank_t joy;
	arcade_input_pkg::dl_write_t dl;
	logic dual_stick;
	logic snd_stat;
	arcade_input_pkg::port_bank_t ports;

	logic check_en;
	logic test_end;
	logic [7:0] test_id;
	arcade_input_pkg::port_bank_t expected;
	int errors;
	int checks;
	int tests_run;
	int tests_failed;
	int bad_steps = 0;
	int step_count = 0;

	// Four words per step as test, operation, argument and expected ports
	logic [39:0] pattern [0:4*MAX_STEPS-1];

	always #5 clk_sys = ~clk_sys;

	arcade_inputs_top #(
		.DIP_BYTES (arcade_input_pkg::DIP_BYTES_DEFAULT)
	) DUT (
		.clk_sys (clk_sys),
		.reset (reset),
		.ps2_key (ps2_key),
		.joy (joy),
		.dl (dl),
		.dual_stick (dual_stick),
		.snd_stat (snd_stat),
		.ports (ports)
	);

	input_checker port_check (
		.clk_sys (clk_sys),
		.ports (ports),
		.check_en (check_en),
		.expected (expected),
		.test_end (test_end),
		.test_id (test_id),
		.errors (errors),
		.checks (checks),
		.tests_run (tests_run),
		.tests_failed (tests_failed)
	);

	// ========================================================================
	// Step driver
	// ========================================================================
	task automatic run_step(input logic [7:0] test, input logic [3:0] op,
		input logic [39:0] arg, input logic [39:0] want);
		@(posedge clk_sys);
		test_id <= test;
		case (op)
			// Keyboard event flips the toggle bit
			4'd1: ps2_key <= {~ps2_key[10], arg[8], 1'b0, arg[7:0]};
			4'd2: joy <= arg;
			4'd3: dl <= '{wr: 1'b1, index: arcade_input_pkg::GAME_SELECT_INDEX,
				addr: 25'd0, data: arg[7:0]};
			4'd4: dl <= '{wr: 1'b1, index: arcade_input_pkg::DIP_INDEX,
				addr: 25'(arg[23:8]), data: arg[7:0]};
			4'd5: {snd_stat, dual_stick} <= arg[1:0];
			4'd6: begin
				check_en <= 1'b1;
				expected <= want;
			end
			default: begin
				$display("Unknown operation %0d in pattern step of test %0d", op, test);
				bad_steps++;
			end
		endcase
		@(posedge clk_sys);
		dl.wr <= 1'b0;
		check_en <= 1'b0;
		repeat (6) @(posedge clk_sys);
	endtask

	task automatic end_test();
		@(posedge clk_sys);
		test_end <= 1'b1;
		@(posedge clk_sys);
		test_end <= 1'b0;
	endtask

	task automatic pulse_reset();
		@(posedge clk_sys);
		reset <= 1'b1;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
	endtask

	initial begin
		int lines;
		reset = 1'b1;
		ps2_key = '0;
		joy = '0;
		dl = '0;
		dual_stick = 1'b0;
		snd_stat = 1'b0;
		check_en = 1'b0;
		test_end = 1'b0;
		test_id = 8'd0;
		expected = '0;
		for (int i = 0; i < 4 * MAX_STEPS; i++) begin
			pattern[i] = '0;
		end
		$readmemh("bench/input_patterns.txt", pattern);
		lines = 0;
		for (int i = 0; i < MAX_STEPS; i++) begin
			if (pattern[4*i+1] == '0)
				break;
			lines = i + 1;
		end
		step_count = lines;
		if (lines == 0) begin
			$display("No steps read from bench/input_patterns.txt");
			bad_steps++;
		end

		repeat (8) @(posedge clk_sys);
		reset <= 1'b0;
		for (int i = 0; i < lines; i++) begin
			if (pattern[4*i][7:0] != test_id && test_id != 8'd0)
				end_test();
			run_step(pattern[4*i][7:0], pattern[4*i+1][3:0], pattern[4*i+2], pattern[4*i+3]);
		end
		if (lines != 0)
			end_test();

		// Reset again while the Power Drive gears are still set
		pulse_reset();
		repeat (2) @(posedge clk_sys);

		$display("Tests run %0d, failed %0d, checks %0d, wrong bytes %0d, bad steps %0d",
			tests_run, tests_failed, checks, errors, bad_steps);
		if (errors == 0 && tests_failed == 0 && bad_steps == 0 && tests_run > 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// Ten cycles per step plus margin for reset
	initial begin
		wait (step_count != 0);
		repeat (step_count * 10 + 200) @(posedge clk_sys);
		$display("Watchdog expired before the pattern steps finished");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- all.f
rtl/arcade_input_pkg.sv
rtl/key_decoder.sv
rtl/config_regs.sv
rtl/gear_shifters.sv
rtl/input_ports.sv
rtl/arcade_inputs_top.sv
bench/input_checker.sv
bench/arcade_inputs_sva.sv
bench/tb_arcade_inputs.sv

//--- Makefile
TOP = tb_arcade_inputs

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	! grep -q "=== FAIL ===" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/input_patterns.txt
// test op arg expected; op 1 key, 2 joy, 3 select, 4 dip, 5 mode, 6 check
// key arg {pressed, code}, dip arg {addr, data}, mode arg {snd_stat, dual_stick}
01 6 0 FFFFFFFFDF
01 5 2 0
01 6 0 7FFFFFFFDF
01 3 2 0
01 6 0 FFFF7FFFDF
01 3 3 0
01 6 0 FFFFFFFF7F
01 3 9 0
01 6 0 FFFFFFFFFF
01 5 0 0
02 3 0 0
02 4 005A 0
02 4 01FE 0
02 6 0 FF5AFFFFFF
02 4 0800 0
02 6 0 FF5AFFFFFF
03 1 175 0
03 6 0 FF5AFFFEFF
03 1 075 0
03 1 11C 0
03 6 0 FF5AEFFFFF
03 1 01C 0
03 2 180020 0
03 6 0 FD5AFFDFFE
03 2 0 0
04 3 1 0
04 1 174 0
04 2 800 0
04 5 1 0
04 6 0 FF5AF9F6FF
04 5 0 0
04 6 0 FF5AFFFFFF
04 1 074 0
04 2 0 0
05 3 2 0
05 1 112 0
05 1 012 0
05 2 8000000 0
05 2 0 0
05 1 136 0
05 2 20000000 0
05 6 0 FF5AFDFDF9
05 1 036 0
05 2 0 0
06 3 3 0
06 6 0 FF5AFAFFFF
06 1 114 0
06 1 014 0
06 1 114 0
06 1 014 0
06 1 114 0
06 1 014 0
06 1 114 0
06 1 014 0
06 1 114 0
06 1 014 0
06 6 0 FF5ADAFFFF
06 1 111 0
06 1 011 0
06 6 0 FF5AEAFFFF
06 1 105 0
06 6 0 FF5AFAFFF7
06 1 005 0
06 1 106 0
06 6 0 FF5AFFFFFB
06 1 006 0
